// File: Bender.yml
package:
  name: multi_uart_rx

dependencies: {}

sources:
  # package first, then leaf modules, then the top level.
  - files:
      - verilog/uart_rx_pkg.sv
      - verilog/rx_baud_gen.sv
      - verilog/rx_state.sv
      - verilog/rx_channel.sv
      - verilog/rx_wb_regs.sv
      - verilog/multi_uart_rx.sv

  # directed testbench.
  - target: test
    files:
      - verif/multi_uart_rx_tb.sv

# top modules: multi_uart_rx (RTL), multi_uart_rx_tb (simulation).
# the same compile order is kept in multi_uart_rx.f.

// File: multi_uart_rx.f
verilog/uart_rx_pkg.sv
verilog/rx_baud_gen.sv
verilog/rx_state.sv
verilog/rx_channel.sv
verilog/rx_wb_regs.sv
verilog/multi_uart_rx.sv
verif/multi_uart_rx_tb.sv

// File: verif/multi_uart_rx_tb.sv
`timescale 1ns/100ps
`default_nettype none

module multi_uart_rx_tb;
    import uart_rx_pkg::*;

    logic              clk;
    logic              reset;
    logic [NUM_CH-1:0] rxd;
    wb_req_t           wb_req;
    wb_rsp_t           wb_rsp;
    logic              irq;

    multi_uart_rx u_multi_uart_rx (
        .clk    (clk),
        .reset  (reset),
        .rxd    (rxd),
        .wb_req (wb_req),
        .wb_rsp (wb_rsp),
        .irq    (irq)
    );

    initial
    begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    task automatic abort_run();
        $display("Test failed");
        $fatal(1);
    endtask

    function automatic rx_data_view_t make_data_view(input logic valid, input logic overrun,
                                                     input logic perr, input logic ferr,
                                                     input logic [7:0] data);
        rx_data_view_t v;
        v            = '0;
        v.valid      = valid;
        v.overrun    = overrun;
        v.parity_err = perr;
        v.frame_err  = ferr;
        v.data       = data;
        return v;
    endfunction

    function automatic rx_status_view_t make_status_view(input logic [NUM_CH-1:0] ready,
                                                         input logic [NUM_CH-1:0] overrun);
        rx_status_view_t v;
        v         = '0;
        v.ready   = ready;
        v.overrun = overrun;
        return v;
    endfunction

    task automatic check_data(input string what, input rx_data_view_t got,
                              input rx_data_view_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns: %s: got %h, expected %h", $time, what, got, exp);
            abort_run();
        end
    endtask

    task automatic check_status(input string what, input rx_status_view_t got,
                                input rx_status_view_t exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns: %s: ready %b overrun %b, expected ready %b overrun %b",
                     $time, what, got.ready, got.overrun, exp.ready, exp.overrun);
            abort_run();
        end
    endtask

    task automatic check_irq(input string what, input logic got, input logic exp);
        if (got !== exp)
        begin
            $display("[FAIL] %0t ns: %s: irq is %b, expected %b", $time, what, got, exp);
            abort_run();
        end
    endtask

    // one bit time on one line, ends 1 ns after a rising edge.
    task automatic drive_bit(input int ch, input logic value);
        rxd[ch] = value;
        repeat (BAUD_DIV * OVERSAMPLE) @(posedge clk);
        #1;
    endtask

    task automatic send_frame(input int ch, input logic [7:0] data, input logic bad_parity,
                              input logic bad_stop);
        logic parity_bit;
        parity_bit = (^data) ^ bad_parity;                  // even parity.
        drive_bit(ch, 1'b0);
        for (int i = 0; i < 8; i++)
            drive_bit(ch, data[i]);                         // lsb first.
        drive_bit(ch, parity_bit);
        drive_bit(ch, ~bad_stop);
        rxd[ch] = 1'b1;
    endtask

    // two back-to-back frames on every channel at once.
    task automatic send_all(input logic [NUM_CH-1:0][7:0] first,
                            input logic [NUM_CH-1:0][7:0] second);
        fork
            begin
                send_frame(0, first[0], 1'b0, 1'b0);
                send_frame(0, second[0], 1'b0, 1'b0);
            end
            begin
                send_frame(1, first[1], 1'b0, 1'b0);
                send_frame(1, second[1], 1'b0, 1'b0);
            end
            begin
                send_frame(2, first[2], 1'b0, 1'b0);
                send_frame(2, second[2], 1'b0, 1'b0);
            end
            begin
                send_frame(3, first[3], 1'b0, 1'b0);
                send_frame(3, second[3], 1'b0, 1'b0);
            end
        join
    endtask

    task automatic wait_ack();
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        while (!wb_rsp.ack)
        begin
            if (waited == 16)
            begin
                $display("no Wishbone ack within 16 clock cycles");
                abort_run();
            end
            waited++;
            @(posedge clk);
            #1;
        end
    endtask

    task automatic wb_read(input logic [WB_ADR_W-1:0] adr, output rx_reg_word_u word);
        wb_req     = '0;
        wb_req.cyc = 1'b1;
        wb_req.stb = 1'b1;
        wb_req.adr = adr;
        wait_ack();
        word   = wb_rsp.dat_r;
        wb_req = '0;                                        // drop the cycle after ack.
    endtask

    task automatic wb_write(input logic [WB_ADR_W-1:0] adr, input logic [31:0] data);
        wb_req       = '0;
        wb_req.cyc   = 1'b1;
        wb_req.stb   = 1'b1;
        wb_req.we    = 1'b1;
        wb_req.adr   = adr;
        wb_req.dat_w = data;
        wait_ack();
        wb_req = '0;
    endtask

    task automatic wait_irq();
        int waited;
        waited = 0;
        while (!irq)
        begin
            if (waited == 2000)
            begin
                $display("irq did not rise within 2000 clock cycles");
                abort_run();
            end
            waited++;
            @(posedge clk);
            #1;
        end
    endtask

    // poll status until the given ready bits are all set.
    task automatic wait_status(input logic [NUM_CH-1:0] ready);
        rx_reg_word_u word;
        int           reads;
        reads = 0;
        wb_read(STATUS_ADR, word);
        while ((word.status.ready & ready) != ready)
        begin
            if (reads == 500)
            begin
                $display("status bits did not appear within 500 status reads");
                abort_run();
            end
            reads++;
            wb_read(STATUS_ADR, word);
        end
    endtask

    task automatic test_reset_state();
        rx_reg_word_u word;
        wb_read(STATUS_ADR, word);
        check_status("status after reset", word.status, make_status_view('0, '0));
        check_irq("irq after reset", irq, 1'b0);
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            wb_read(WB_ADR_W'(ch), word);
            check_data($sformatf("data %0d after reset", ch), word.chan, '0);
        end
    endtask

    task automatic test_single_byte();
        rx_reg_word_u word;
        logic [7:0]   b;
        b = 8'($urandom_range(255));
        send_frame(0, b, 1'b0, 1'b0);
        wait_irq();
        wb_read(STATUS_ADR, word);
        check_status("status after one byte", word.status, make_status_view(4'b0001, '0));
        wb_read(WB_ADR_W'(0), word);
        check_data("first read of channel 0", word.chan, make_data_view(1, 0, 0, 0, b));
        wb_read(WB_ADR_W'(0), word);
        check_data("second read of channel 0", word.chan, make_data_view(0, 0, 0, 0, b));
        check_irq("irq after read", irq, 1'b0);
    endtask

    task automatic test_all_channels();
        rx_reg_word_u             word;
        logic [NUM_CH-1:0][7:0]   first;
        logic [NUM_CH-1:0][7:0]   second;
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            first[ch]  = 8'($urandom_range(255));
            second[ch] = 8'($urandom_range(255));
        end
        send_all(first, second);
        wait_status('1);
        wb_read(STATUS_ADR, word);
        check_status("status after all channels", word.status, make_status_view('1, '1));
        for (int ch = 0; ch < NUM_CH; ch++)
        begin
            wb_read(WB_ADR_W'(ch), word);
            check_data($sformatf("channel %0d second byte", ch), word.chan,
                       make_data_view(1, 1, 0, 0, second[ch]));
        end
        check_irq("irq after draining", irq, 1'b0);
    endtask

    task automatic test_error_flags();
        rx_reg_word_u word;
        logic [7:0]   b;
        b = 8'($urandom_range(255));
        send_frame(1, b, 1'b1, 1'b0);
        wait_status(4'b0010);
        wb_read(WB_ADR_W'(1), word);
        check_data("bad parity on channel 1", word.chan, make_data_view(1, 0, 1, 0, b));
        b = 8'($urandom_range(255));
        send_frame(3, b, 1'b0, 1'b1);
        wait_status(4'b1000);
        wb_read(WB_ADR_W'(3), word);
        check_data("low stop bit on channel 3", word.chan, make_data_view(1, 0, 0, 1, b));
    endtask

    task automatic test_overrun();
        rx_reg_word_u word;
        rx_reg_word_u clear;
        logic [7:0]   b1;
        logic [7:0]   b2;
        b1 = 8'($urandom_range(255));
        b2 = 8'($urandom_range(255));
        send_frame(2, b1, 1'b0, 1'b0);
        send_frame(2, b2, 1'b0, 1'b0);
        wait_status(4'b0100);
        wb_read(STATUS_ADR, word);
        check_status("overrun on channel 2", word.status, make_status_view(4'b0100, 4'b0100));
        clear                = '0;
        clear.status.overrun = 4'b0100;
        wb_write(STATUS_ADR, clear);
        wb_read(STATUS_ADR, word);
        check_status("overrun cleared", word.status, make_status_view(4'b0100, '0));
        wb_read(WB_ADR_W'(2), word);
        check_data("channel 2 after overrun", word.chan, make_data_view(1, 0, 0, 0, b2));
        wb_read(STATUS_ADR, word);
        check_status("status at the end", word.status, make_status_view('0, '0));
    endtask

    initial
    begin
        void'($urandom(50));
        reset  = 1'b1;
        rxd    = '1;                                        // lines idle high.
        wb_req = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        test_reset_state();
        test_single_byte();
        test_all_channels();
        test_error_flags();
        test_overrun();
        $display("Test completed successfully");
        $finish;
    end

endmodule

`default_nettype wire

// File: verilog/multi_uart_rx.sv
`timescale 1ns/100ps
`default_nettype none

module multi_uart_rx (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [uart_rx_pkg::NUM_CH-1:0] rxd,
    input  uart_rx_pkg::wb_req_t           wb_req,
    output uart_rx_pkg::wb_rsp_t           wb_rsp,
    output logic                           irq
);
    import uart_rx_pkg::*;

    logic              tick;                        // shared 16x tick.
    logic [NUM_CH-1:0] frame_valid;
    rx_frame_t         frames [NUM_CH];

    rx_baud_gen u_rx_baud_gen (
        .clk   (clk),
        .reset (reset),
        .tick  (tick)
    );

    for (genvar g = 0; g < NUM_CH; g++)
    begin : g_ch
        rx_channel u_rx_channel (
            .clk         (clk),
            .reset       (reset),
            .tick        (tick),
            .rxd         (rxd[g]),
            .frame_valid (frame_valid[g]),
            .frame       (frames[g])
        );
    end

    rx_wb_regs u_rx_wb_regs (
        .clk         (clk),
        .reset       (reset),
        .frame_valid (frame_valid),
        .frames      (frames),
        .wb_req      (wb_req),
        .wb_rsp      (wb_rsp),
        .irq         (irq)
    );

endmodule

`default_nettype wire

// File: verilog/rx_baud_gen.sv
`timescale 1ns/100ps
`default_nettype none

module rx_baud_gen (
    input  logic clk,
    input  logic reset,
    output logic tick
);
    import uart_rx_pkg::*;

    logic [BAUD_CNT_W-1:0] div_cnt;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end
        else
        begin
            if (div_cnt == BAUD_LAST)
            begin
                div_cnt <= '0;
                tick    <= 1'b1;                    // one pulse per wrap.
            end
            else
            begin
                div_cnt <= div_cnt + 1'b1;
                tick    <= 1'b0;
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/rx_channel.sv
`timescale 1ns/100ps
`default_nettype none

module rx_channel (
    input  logic                   clk,
    input  logic                   reset,
    input  logic                   tick,
    input  logic                   rxd,
    output logic                   frame_valid,
    output uart_rx_pkg::rx_frame_t frame
);
    import uart_rx_pkg::*;

    logic                  rxd_meta;
    logic                  rxd_sync;
    logic                  rxd_prev;
    logic                  fall_edge;
    logic                  busy;                    // frame in progress.
    logic [TICK_CNT_W-1:0] tick_cnt;
    logic                  mid_strobe;
    logic                  end_strobe;
    logic                  sampling_strobe;
    logic                  held_sample;
    logic [7:0]            shift_q;
    logic                  parity_acc;
    logic                  parity_err_q;
    logic                  data_is_available;
    logic                  is_parity_stage;
    logic                  data_is_valid;
    logic                  valid_prev;
    logic                  valid_rise;

    assign fall_edge       = rxd_prev & ~rxd_sync;
    assign sampling_strobe = mid_strobe | end_strobe;
    assign valid_rise      = data_is_valid & ~valid_prev;

    // line idles high.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            rxd_meta <= 1'b1;
            rxd_sync <= 1'b1;
            rxd_prev <= 1'b1;
        end
        else
        begin
            rxd_meta <= rxd;
            rxd_sync <= rxd_meta;
            rxd_prev <= rxd_sync;
        end
    end

    // first strobe half a bit after the start edge, then one per bit.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            busy       <= 1'b0;
            tick_cnt   <= '0;
            mid_strobe <= 1'b0;
            end_strobe <= 1'b0;
        end
        else
        begin
            mid_strobe <= 1'b0;
            end_strobe <= valid_rise;               // sends the fsm back to idle.
            if (valid_rise)
            begin
                busy <= 1'b0;
            end
            else if (!busy && fall_edge)
            begin
                busy     <= 1'b1;
                tick_cnt <= TICK_HALF;
            end
            else if (busy && tick)
            begin
                if (tick_cnt == '0)
                begin
                    mid_strobe <= 1'b1;
                    tick_cnt   <= TICK_LAST;
                end
                else
                begin
                    tick_cnt <= tick_cnt - 1'b1;
                end
            end
        end
    end

    rx_state u_rx_state (
        .clk               (clk),
        .reset             (reset),
        .start_detected    (busy),
        .sampling_strobe   (sampling_strobe),
        .data_is_available (data_is_available),
        .is_parity_stage   (is_parity_stage),
        .data_is_valid     (data_is_valid)
    );

    // the held sample is one bit behind the fsm flags.
    always_ff @(posedge clk)
    begin
        if (!busy && fall_edge)
            parity_acc <= 1'b0;
        if (sampling_strobe)
        begin
            held_sample <= rxd_sync;
            if (data_is_available)
            begin
                shift_q    <= {held_sample, shift_q[7:1]};  // lsb first.
                parity_acc <= parity_acc ^ held_sample;
            end
            if (is_parity_stage)
                parity_err_q <= parity_acc ^ held_sample;   // even parity.
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            frame_valid <= 1'b0;
            valid_prev  <= 1'b0;
        end
        else
        begin
            frame_valid <= valid_rise;
            valid_prev  <= data_is_valid;
        end
    end

    always_ff @(posedge clk)
    begin
        if (valid_rise)
        begin
            frame.data       <= shift_q;
            frame.parity_err <= parity_err_q;
            frame.frame_err  <= ~held_sample;       // stop bit must be high.
        end
    end

endmodule

`default_nettype wire

// File: verilog/rx_state.sv
`timescale 1ns/100ps
`default_nettype none

module rx_state (
    input  logic clk,
    input  logic reset,
    input  logic start_detected,
    input  logic sampling_strobe,
    output logic data_is_available,
    output logic is_parity_stage,
    output logic data_is_valid
);
    import uart_rx_pkg::*;

    logic [3:0] state;

    // flags follow the state one cycle later.
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            data_is_available <= 1'b0;
            is_parity_stage   <= 1'b0;
            data_is_valid     <= 1'b0;
        end
        else
        begin
            data_is_available <= (state >= RX_DATA_BIT_0) && (state <= RX_DATA_BIT_7);
            is_parity_stage   <= (state == RX_PARITY_BIT);
            data_is_valid     <= (state == RX_STOP_BIT);    // lines up with the stop check.
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            state <= RX_IDLE;
        end
        else if (sampling_strobe)
        begin
            case (state)
                RX_IDLE:
                begin
                    if (start_detected)
                        state <= RX_START_BIT;
                end
                RX_START_BIT:
                    state <= RX_DATA_BIT_0;
                RX_DATA_BIT_0,
                RX_DATA_BIT_1,
                RX_DATA_BIT_2,
                RX_DATA_BIT_3,
                RX_DATA_BIT_4,
                RX_DATA_BIT_5,
                RX_DATA_BIT_6,
                RX_DATA_BIT_7:
                    state <= state + 4'd1;              // bit 7 steps on to parity.
                RX_PARITY_BIT:
                    state <= RX_STOP_BIT;
                RX_STOP_BIT:
                    state <= RX_IDLE;
                default:
                    state <= RX_IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

// File: verilog/rx_wb_regs.sv
`timescale 1ns/100ps
`default_nettype none

module rx_wb_regs (
    input  logic                           clk,
    input  logic                           reset,
    input  logic [uart_rx_pkg::NUM_CH-1:0] frame_valid,
    input  uart_rx_pkg::rx_frame_t         frames [uart_rx_pkg::NUM_CH],
    input  uart_rx_pkg::wb_req_t           wb_req,
    output uart_rx_pkg::wb_rsp_t           wb_rsp,
    output logic                           irq
);
    import uart_rx_pkg::*;

    rx_frame_t         frame_q [NUM_CH];
    logic [NUM_CH-1:0] valid_q;
    logic [NUM_CH-1:0] overrun_q;
    logic              req;                         // request not yet acked.
    logic [CH_W-1:0]   ch_sel;
    logic [NUM_CH-1:0] rd_clr;
    logic [NUM_CH-1:0] ovr_clr;
    rx_reg_word_u      rd_word;
    rx_reg_word_u      wr_word;

    assign req     = wb_req.cyc & wb_req.stb & ~wb_rsp.ack;
    assign ch_sel  = wb_req.adr[CH_W-1:0];
    assign wr_word = wb_req.dat_w;
    assign irq     = |valid_q;

    always_comb
    begin
        for (int i = 0; i < NUM_CH; i++)
        begin
            rd_clr[i] = req & ~wb_req.we & (wb_req.adr == WB_ADR_W'(i));
        end
        ovr_clr = wr_word.status.overrun
                & {NUM_CH{req & wb_req.we & (wb_req.adr == STATUS_ADR)}};   // write one to clear.
    end

    always_comb
    begin
        rd_word = '0;
        if (wb_req.adr == STATUS_ADR)
        begin
            rd_word.status.ready   = valid_q;
            rd_word.status.overrun = overrun_q;
        end
        else if (wb_req.adr < STATUS_ADR)
        begin
            rd_word.chan.valid      = valid_q[ch_sel];
            rd_word.chan.overrun    = overrun_q[ch_sel];
            rd_word.chan.parity_err = frame_q[ch_sel].parity_err;
            rd_word.chan.frame_err  = frame_q[ch_sel].frame_err;
            rd_word.chan.data       = frame_q[ch_sel].data;
        end
    end

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wb_rsp    <= '0;
            valid_q   <= '0;
            overrun_q <= '0;
            for (int i = 0; i < NUM_CH; i++)
            begin
                frame_q[i] <= '0;
            end
        end
        else
        begin
            wb_rsp.ack <= req;                      // single cycle ack, no wait states.
            if (req)
                wb_rsp.dat_r <= rd_word;
            for (int i = 0; i < NUM_CH; i++)
            begin
                if (rd_clr[i])
                begin
                    valid_q[i]   <= 1'b0;
                    overrun_q[i] <= 1'b0;
                end
                if (ovr_clr[i])
                    overrun_q[i] <= 1'b0;
                if (frame_valid[i])
                begin
                    frame_q[i] <= frames[i];        // newest frame always wins.
                    valid_q[i] <= 1'b1;
                    if (valid_q[i] && !rd_clr[i])
                        overrun_q[i] <= 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

// File: verilog/uart_rx_pkg.sv
`default_nettype none

package uart_rx_pkg;

    localparam int NUM_CH     = 4;
    localparam int BAUD_DIV   = 4;                  // clk cycles per oversampling tick.
    localparam int OVERSAMPLE = 16;                 // ticks per bit.
    localparam int WB_ADR_W   = 3;
    localparam int CH_W       = $clog2(NUM_CH);
    localparam int BAUD_CNT_W = $clog2(BAUD_DIV);
    localparam int TICK_CNT_W = $clog2(OVERSAMPLE);

    localparam logic [WB_ADR_W-1:0]   STATUS_ADR = WB_ADR_W'(NUM_CH);
    localparam logic [BAUD_CNT_W-1:0] BAUD_LAST  = BAUD_CNT_W'(BAUD_DIV - 1);
    localparam logic [TICK_CNT_W-1:0] TICK_LAST  = TICK_CNT_W'(OVERSAMPLE - 1);
    localparam logic [TICK_CNT_W-1:0] TICK_HALF  = TICK_CNT_W'(OVERSAMPLE / 2 - 1);

    // frame sequencer states.
    localparam logic [3:0] RX_IDLE       = 4'b0000;
    localparam logic [3:0] RX_START_BIT  = 4'b0001;
    localparam logic [3:0] RX_DATA_BIT_0 = 4'b0010;
    localparam logic [3:0] RX_DATA_BIT_1 = 4'b0011;
    localparam logic [3:0] RX_DATA_BIT_2 = 4'b0100;
    localparam logic [3:0] RX_DATA_BIT_3 = 4'b0101;
    localparam logic [3:0] RX_DATA_BIT_4 = 4'b0110;
    localparam logic [3:0] RX_DATA_BIT_5 = 4'b0111;
    localparam logic [3:0] RX_DATA_BIT_6 = 4'b1000;
    localparam logic [3:0] RX_DATA_BIT_7 = 4'b1001;
    localparam logic [3:0] RX_PARITY_BIT = 4'b1010;
    localparam logic [3:0] RX_STOP_BIT   = 4'b1011;

    typedef struct packed {
        logic       parity_err;
        logic       frame_err;
        logic [7:0] data;
    } rx_frame_t;

    typedef struct packed {
        logic                cyc;
        logic                stb;
        logic                we;
        logic [WB_ADR_W-1:0] adr;
        logic [31:0]         dat_w;
    } wb_req_t;

    typedef struct packed {
        logic        ack;
        logic [31:0] dat_r;
    } wb_rsp_t;

    typedef struct packed {
        logic [19:0] pad;
        logic        valid;
        logic        overrun;
        logic        parity_err;
        logic        frame_err;
        logic [7:0]  data;
    } rx_data_view_t;

    typedef struct packed {
        logic [31-2*NUM_CH:0] pad;
        logic [NUM_CH-1:0]    overrun;
        logic [NUM_CH-1:0]    ready;
    } rx_status_view_t;

    // one register word, read as a channel data register or as status.
    typedef union packed {
        rx_data_view_t   chan;
        rx_status_view_t status;
    } rx_reg_word_u;

endpackage

`default_nettype wire
